/* include/abr_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~
// abr accelerator constants
// modulus, polynomial size, memory geometry and host register map
// ~~~~~~~~~~~~~~~~~~~~
`ifndef ABR_SETTINGS_SVH
`define ABR_SETTINGS_SVH

// arithmetic
`define ABR_Q           3329
`define ABR_N           32
`define ABR_LFSR_TAPS   16'hB400

// memory geometry
`define ABR_MEM_DEPTH   256
`define ABR_ADDR_W      8
`define ABR_COEFF_W     12
`define ABR_SEED_W      16

// host bus
`define ABR_HOST_ADDR_W 10
`define ABR_HOST_DATA_W 32

// host word addresses
`define ABR_REG_CMD     0
`define ABR_REG_SEED    1
`define ABR_REG_BASES   2
`define ABR_REG_STATUS  3
`define ABR_WIN_BASE    256

`endif

/* logic/abr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr shared types
// coefficient, address and host word types, opcodes and engine states
// ~~~~~~~~~~~~~~~~~~~~
`include "abr_settings.svh"

package abr_pkg;

  typedef logic [`ABR_COEFF_W-1:0]     coeff_t;
  typedef logic [`ABR_ADDR_W-1:0]      mem_addr_t;
  typedef logic [`ABR_HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [`ABR_HOST_DATA_W-1:0] host_data_t;

  // host command opcodes
  typedef enum logic [1:0] {
    ABR_OP_NONE   = 2'd0,
    ABR_OP_SAMPLE = 2'd1,
    ABR_OP_PWA    = 2'd2,
    ABR_OP_PWM    = 2'd3
  } abr_op_e;

  // pointwise engine FSM
  typedef enum logic [2:0] {
    PWO_IDLE,
    PWO_RD_A,
    PWO_RD_B,
    PWO_CALC,
    PWO_WR
  } pwo_state_e;

endpackage

/* logic/abr_mem_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr memory client bundle
// one client's request and the arbiter's grant and read response
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface abr_mem_if;
  import abr_pkg::*;

  logic      req;
  logic      we;
  mem_addr_t addr;
  coeff_t    wdata;
  logic      gnt;
  logic      rvalid;
  coeff_t    rdata;

  modport client (output req, we, addr, wdata, input gnt, rvalid, rdata);
  modport arb    (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

/* logic/abr_reg_front.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr host front end
// register file, command pulses, busy flag and the memory window
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "abr_settings.svh"

module abr_reg_front (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   req_i,
  input  logic                   we_i,
  input  abr_pkg::host_addr_t    addr_i,
  input  abr_pkg::host_data_t    wdata_i,
  output logic                   ack_o,
  output abr_pkg::host_data_t    rdata_o,
  output logic                   samp_start_o,
  output logic                   pwo_start_o,
  output abr_pkg::abr_op_e       pwo_op_o,
  output logic [`ABR_SEED_W-1:0] seed_o,
  output abr_pkg::mem_addr_t     src_a_o,
  output abr_pkg::mem_addr_t     src_b_o,
  output abr_pkg::mem_addr_t     dst_o,
  input  logic                   samp_done_i,
  input  logic                   pwo_done_i,
  abr_mem_if.client              mem
);
  import abr_pkg::*;

  logic       win_hit;
  logic       reg_acc;
  logic       win_pend_q;
  logic       ack_q;
  logic       busy_q;
  abr_op_e    cmd_op;
  host_addr_t win_off;
  host_data_t reg_rdata;
  host_data_t rdata_q;

  always_comb begin
    win_hit = (addr_i >= host_addr_t'(`ABR_WIN_BASE)) &&
              (addr_i < host_addr_t'(`ABR_WIN_BASE + `ABR_MEM_DEPTH));
    win_off = addr_i - host_addr_t'(`ABR_WIN_BASE);
    // register access only in the first cycle of a request
    reg_acc = req_i & ~win_hit & ~ack_q;
    cmd_op  = abr_op_e'(wdata_i[1:0]);
  end

  always_comb begin
    case (addr_i)
      host_addr_t'(`ABR_REG_SEED):   reg_rdata = host_data_t'(seed_o);
      host_addr_t'(`ABR_REG_BASES):  reg_rdata = host_data_t'({dst_o, src_b_o, src_a_o});
      host_addr_t'(`ABR_REG_STATUS): reg_rdata = host_data_t'(busy_q);
      default:                       reg_rdata = '0;
    endcase
  end

  // window client, lowest priority at the arbiter
  assign mem.req   = req_i & win_hit & ~ack_q & ~win_pend_q;
  assign mem.we    = we_i;
  assign mem.addr  = win_off[`ABR_ADDR_W-1:0];
  assign mem.wdata = wdata_i[`ABR_COEFF_W-1:0];

  // window reads complete with the returning data
  assign ack_o   = ack_q | mem.rvalid;
  assign rdata_o = mem.rvalid ? host_data_t'(mem.rdata) : rdata_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ack_q        <= 1'b0;
      win_pend_q   <= 1'b0;
      busy_q       <= 1'b0;
      samp_start_o <= 1'b0;
      pwo_start_o  <= 1'b0;
      pwo_op_o     <= ABR_OP_NONE;
      seed_o       <= '0;
      src_a_o      <= '0;
      src_b_o      <= '0;
      dst_o        <= '0;
    end else begin
      ack_q        <= reg_acc | (mem.gnt & mem.we);
      samp_start_o <= 1'b0;
      pwo_start_o  <= 1'b0;
      if (mem.gnt && !mem.we) begin
        win_pend_q <= 1'b1;
      end else if (mem.rvalid) begin
        win_pend_q <= 1'b0;
      end
      if (samp_done_i || pwo_done_i) begin
        busy_q <= 1'b0;
      end
      if (reg_acc && we_i) begin
        case (addr_i)
          host_addr_t'(`ABR_REG_CMD): begin
            // commands while busy are dropped
            if (!busy_q && cmd_op != ABR_OP_NONE) begin
              busy_q       <= 1'b1;
              samp_start_o <= (cmd_op == ABR_OP_SAMPLE);
              pwo_start_o  <= (cmd_op != ABR_OP_SAMPLE);
              pwo_op_o     <= cmd_op;
            end
          end
          host_addr_t'(`ABR_REG_SEED): seed_o <= wdata_i[`ABR_SEED_W-1:0];
          host_addr_t'(`ABR_REG_BASES): begin
            src_a_o <= wdata_i[`ABR_ADDR_W-1:0];
            src_b_o <= wdata_i[2*`ABR_ADDR_W-1:`ABR_ADDR_W];
            dst_o   <= wdata_i[3*`ABR_ADDR_W-1:2*`ABR_ADDR_W];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reg_acc && !we_i) begin
      rdata_q <= reg_rdata;
    end
  end

endmodule

/* logic/abr_sampler.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr uniform sampler
// LFSR candidates below Q are written to consecutive destination words
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "abr_settings.svh"

module abr_sampler (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   start_i,
  input  logic [`ABR_SEED_W-1:0] seed_i,
  input  abr_pkg::mem_addr_t     dst_i,
  output logic                   done_o,
  abr_mem_if.client              mem
);
  import abr_pkg::*;

  localparam coeff_t    QMOD = coeff_t'(`ABR_Q);
  localparam mem_addr_t LAST = mem_addr_t'(`ABR_N - 1);

  logic [`ABR_SEED_W-1:0] lfsr_q;
  logic [`ABR_SEED_W-1:0] lfsr_nxt;
  logic                   active_q;
  logic                   wr_pend_q;
  logic                   step;
  mem_addr_t              cnt_q;
  mem_addr_t              dst_q;
  coeff_t                 cand_q;

  // galois shift right, taps folded in when a one drops out
  always_comb begin
    lfsr_nxt = (lfsr_q >> 1) ^ (lfsr_q[0] ? `ABR_LFSR_TAPS : '0);
    step     = active_q & ~wr_pend_q & ~start_i;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      lfsr_q    <= '0;
      active_q  <= 1'b0;
      wr_pend_q <= 1'b0;
      cnt_q     <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        lfsr_q    <= seed_i;
        active_q  <= 1'b1;
        wr_pend_q <= 1'b0;
        cnt_q     <= '0;
      end else if (step) begin
        lfsr_q <= lfsr_nxt;
        // reject candidates at or above Q
        if (lfsr_nxt[`ABR_COEFF_W-1:0] < QMOD) begin
          wr_pend_q <= 1'b1;
        end
      end else if (wr_pend_q && mem.gnt) begin
        wr_pend_q <= 1'b0;
        cnt_q     <= cnt_q + 1'b1;
        if (cnt_q == LAST) begin
          active_q <= 1'b0;
          done_o   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      dst_q <= dst_i;
    end
    if (step) begin
      cand_q <= lfsr_nxt[`ABR_COEFF_W-1:0];
    end
  end

  assign mem.req   = wr_pend_q;
  assign mem.we    = 1'b1;
  assign mem.addr  = dst_q + cnt_q;
  assign mem.wdata = cand_q;

endmodule

/* logic/abr_pwo_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr pointwise engine
// dst[i] = a[i] + b[i] or a[i] * b[i], reduced modulo Q
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "abr_settings.svh"

module abr_pwo_engine (
  input  logic               clk,
  input  logic               rst_b,
  input  logic               start_i,
  input  abr_pkg::abr_op_e   op_i,
  input  abr_pkg::mem_addr_t src_a_i,
  input  abr_pkg::mem_addr_t src_b_i,
  input  abr_pkg::mem_addr_t dst_i,
  output logic               done_o,
  abr_mem_if.client          mem
);
  import abr_pkg::*;

  localparam int unsigned QMOD = `ABR_Q;
  localparam mem_addr_t   LAST = mem_addr_t'(`ABR_N - 1);

  pwo_state_e                state_q;
  abr_op_e                   op_q;
  logic                      rd_pend_q;
  mem_addr_t                 idx_q;
  mem_addr_t                 src_a_q;
  mem_addr_t                 src_b_q;
  mem_addr_t                 dst_q;
  coeff_t                    a_q;
  coeff_t                    b_q;
  coeff_t                    res_q;
  coeff_t                    res_nxt;
  logic [`ABR_COEFF_W:0]     sum;
  logic [2*`ABR_COEFF_W-1:0] prod;

  // operands are below Q so one subtraction covers the sum
  always_comb begin
    sum  = {1'b0, a_q} + {1'b0, b_q};
    prod = a_q * b_q;
    if (op_q == ABR_OP_PWM) begin
      res_nxt = coeff_t'(prod % QMOD);
    end else if (sum >= QMOD) begin
      res_nxt = coeff_t'(sum - QMOD);
    end else begin
      res_nxt = coeff_t'(sum);
    end
  end

  always_comb begin
    mem.req   = 1'b0;
    mem.we    = 1'b0;
    mem.addr  = src_a_q + idx_q;
    mem.wdata = res_q;
    case (state_q)
      PWO_RD_A: mem.req = ~rd_pend_q;
      PWO_RD_B: begin
        mem.req  = ~rd_pend_q;
        mem.addr = src_b_q + idx_q;
      end
      PWO_WR: begin
        mem.req  = 1'b1;
        mem.we   = 1'b1;
        mem.addr = dst_q + idx_q;
      end
      default: mem.req = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q   <= PWO_IDLE;
      op_q      <= ABR_OP_NONE;
      rd_pend_q <= 1'b0;
      idx_q     <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        PWO_IDLE: begin
          if (start_i) begin
            state_q <= PWO_RD_A;
            op_q    <= op_i;
            idx_q   <= '0;
          end
        end
        PWO_RD_A, PWO_RD_B: begin
          // one read in flight, data lands a cycle after the grant
          if (mem.gnt) begin
            rd_pend_q <= 1'b1;
          end
          if (mem.rvalid) begin
            rd_pend_q <= 1'b0;
            state_q   <= (state_q == PWO_RD_A) ? PWO_RD_B : PWO_CALC;
          end
        end
        PWO_CALC: state_q <= PWO_WR;
        PWO_WR: begin
          if (mem.gnt) begin
            if (idx_q == LAST) begin
              state_q <= PWO_IDLE;
              done_o  <= 1'b1;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= PWO_RD_A;
            end
          end
        end
        default: state_q <= PWO_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == PWO_IDLE && start_i) begin
      src_a_q <= src_a_i;
      src_b_q <= src_b_i;
      dst_q   <= dst_i;
    end
    if (mem.rvalid) begin
      if (state_q == PWO_RD_A) begin
        a_q <= mem.rdata;
      end else begin
        b_q <= mem.rdata;
      end
    end
    if (state_q == PWO_CALC) begin
      res_q <= res_nxt;
    end
  end

endmodule

/* logic/abr_mem_arb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr memory arbiter
// fixed priority pwo > sampler > host, read data routed back a cycle later
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module abr_mem_arb (
  input  logic               clk,
  input  logic               rst_b,
  abr_mem_if.arb             pwo,
  abr_mem_if.arb             samp,
  abr_mem_if.arb             host,
  output logic               cs_o,
  output logic               we_o,
  output abr_pkg::mem_addr_t addr_o,
  output abr_pkg::coeff_t    wdata_o,
  input  abr_pkg::coeff_t    rdata_i
);

  logic pwo_rd_q;
  logic samp_rd_q;
  logic host_rd_q;

  // same-cycle grant
  always_comb begin
    pwo.gnt  = pwo.req;
    samp.gnt = samp.req & ~pwo.req;
    host.gnt = host.req & ~pwo.req & ~samp.req;
  end

  // SRAM port follows the winner
  always_comb begin
    cs_o    = pwo.req | samp.req | host.req;
    we_o    = 1'b0;
    addr_o  = '0;
    wdata_o = '0;
    if (pwo.req) begin
      we_o    = pwo.we;
      addr_o  = pwo.addr;
      wdata_o = pwo.wdata;
    end else if (samp.req) begin
      we_o    = samp.we;
      addr_o  = samp.addr;
      wdata_o = samp.wdata;
    end else if (host.req) begin
      we_o    = host.we;
      addr_o  = host.addr;
      wdata_o = host.wdata;
    end
  end

  // remember who owns the read in flight
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      pwo_rd_q  <= 1'b0;
      samp_rd_q <= 1'b0;
      host_rd_q <= 1'b0;
    end else begin
      pwo_rd_q  <= pwo.gnt & ~pwo.we;
      samp_rd_q <= samp.gnt & ~samp.we;
      host_rd_q <= host.gnt & ~host.we;
    end
  end

  assign pwo.rvalid  = pwo_rd_q;
  assign samp.rvalid = samp_rd_q;
  assign host.rvalid = host_rd_q;
  assign pwo.rdata   = rdata_i;
  assign samp.rdata  = rdata_i;
  assign host.rdata  = rdata_i;

endmodule

/* logic/abr_sram.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr coefficient memory
// single port, one cycle read latency
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "abr_settings.svh"

module abr_sram (
  input  logic               clk,
  input  logic               cs_i,
  input  logic               we_i,
  input  abr_pkg::mem_addr_t addr_i,
  input  abr_pkg::coeff_t    wdata_i,
  output abr_pkg::coeff_t    rdata_o
);
  import abr_pkg::*;

  coeff_t mem_q [`ABR_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (cs_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

/* logic/abr_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr accelerator top
// host front end, sampler and pwo engine sharing one SRAM
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "abr_settings.svh"

module abr_top (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                req_i,
  input  logic                we_i,
  input  abr_pkg::host_addr_t addr_i,
  input  abr_pkg::host_data_t wdata_i,
  output logic                ack_o,
  output abr_pkg::host_data_t rdata_o
);
  import abr_pkg::*;

  logic                   samp_start;
  logic                   pwo_start;
  logic                   samp_done;
  logic                   pwo_done;
  abr_op_e                pwo_op;
  logic [`ABR_SEED_W-1:0] seed;
  mem_addr_t              src_a;
  mem_addr_t              src_b;
  mem_addr_t              dst;
  logic                   sram_cs;
  logic                   sram_we;
  mem_addr_t              sram_addr;
  coeff_t                 sram_wdata;
  coeff_t                 sram_rdata;

  abr_mem_if host_mem ();
  abr_mem_if samp_mem ();
  abr_mem_if pwo_mem ();

  abr_reg_front reg_front0 (
    .clk, .rst_b, .req_i, .we_i, .addr_i, .wdata_i, .ack_o, .rdata_o,
    .samp_start_o(samp_start), .pwo_start_o(pwo_start), .pwo_op_o(pwo_op),
    .seed_o(seed), .src_a_o(src_a), .src_b_o(src_b), .dst_o(dst),
    .samp_done_i(samp_done), .pwo_done_i(pwo_done), .mem(host_mem.client)
  );

  abr_sampler sampler0 (
    .clk, .rst_b, .start_i(samp_start), .seed_i(seed), .dst_i(dst),
    .done_o(samp_done), .mem(samp_mem.client)
  );

  abr_pwo_engine pwo0 (
    .clk, .rst_b, .start_i(pwo_start), .op_i(pwo_op), .src_a_i(src_a),
    .src_b_i(src_b), .dst_i(dst), .done_o(pwo_done), .mem(pwo_mem.client)
  );

  abr_mem_arb arb0 (
    .clk, .rst_b, .pwo(pwo_mem.arb), .samp(samp_mem.arb), .host(host_mem.arb),
    .cs_o(sram_cs), .we_o(sram_we), .addr_o(sram_addr), .wdata_o(sram_wdata),
    .rdata_i(sram_rdata)
  );

  abr_sram sram0 (
    .clk, .cs_i(sram_cs), .we_i(sram_we), .addr_i(sram_addr),
    .wdata_i(sram_wdata), .rdata_o(sram_rdata)
  );

endmodule

/* test/tb_clkgen.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 4 ns clock, active low reset held for two cycles
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst_b
);

  localparam int HALF_PERIOD = 2;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release just after the second rising edge
  initial begin
    rst_b = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_b = 1'b1;
  end

endmodule

/* test/abr_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// abr accelerator testbench
// random host traffic, sampler and pointwise runs checked against a model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "abr_settings.svh"

module abr_tb;

  localparam int DRIVE_DLY = 1;
  localparam int ACK_LIMIT = 100;
  localparam int Q         = `ABR_Q;
  localparam int N         = `ABR_N;
  localparam int DEPTH     = `ABR_MEM_DEPTH;
  localparam int ADDR_MASK = `ABR_MEM_DEPTH - 1;
  localparam int N_REG     = 40;
  localparam int N_WIN     = 64;
  localparam int N_SAMP    = 3;
  localparam int N_PWO     = 4;
  localparam int OP_SAMPLE = 1;
  localparam int OP_PWA    = 2;
  localparam int OP_PWM    = 3;
  localparam int HOST_OPS  = 1 + 2 * N_REG + DEPTH + N_WIN + N_SAMP * (N + 6) +
                             N_PWO * (5 * N + 4) + N + 20;
  localparam int WATCHDOG_CYCLES = (N_SAMP + N_PWO) * 400 + HOST_OPS * 20;

  logic        clk;
  logic        rst_b;
  logic        req_i;
  logic        we_i;
  logic [9:0]  addr_i;
  logic [31:0] wdata_i;
  logic        ack_o;
  logic [31:0] rdata_o;

  logic [31:0] model_mem [DEPTH];
  logic [15:0] seed_m;
  logic [23:0] bases_m;

  tb_clkgen clkgen0 (.clk, .rst_b);

  abr_top dut0 (
    .clk, .rst_b, .req_i, .we_i, .addr_i, .wdata_i, .ack_o, .rdata_o
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      stop_on_error($sformatf("ERR %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act));
  endtask

  // one host bus transfer with req held until the ack cycle
  task automatic host_access(input logic we, input int addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    int waited;
    waited  = 0;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr[9:0];
    wdata_i = wdata;
    @(negedge clk);
    while (!ack_o) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        stop_on_error($sformatf("host access to address %0d was never acknowledged", addr));
      end
      @(negedge clk);
    end
    rdata = rdata_o;
    @(posedge clk);
    #DRIVE_DLY;
    req_i = 1'b0;
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic reg_write(input int addr, input logic [31:0] v);
    logic [31:0] rd;
    host_access(1'b1, addr, v, rd);
  endtask

  task automatic reg_check(input int addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    host_access(1'b0, addr, 32'h0, rd);
    check_val(name, exp, rd);
  endtask

  task automatic win_write(input int addr, input logic [31:0] v);
    logic [31:0] rd;
    host_access(1'b1, `ABR_WIN_BASE + addr, v, rd);
    model_mem[addr] = v & 32'hFFF;
  endtask

  task automatic win_check(input int addr);
    logic [31:0] rd;
    host_access(1'b0, `ABR_WIN_BASE + addr, 32'h0, rd);
    check_val($sformatf("rdata_o[mem 0x%02h]", addr), model_mem[addr], rd);
  endtask

  task automatic compare_region(input int base, input int len);
    for (int k = 0; k < len; k++) begin
      win_check((base + k) & ADDR_MASK);
    end
  endtask

  // poll busy until the status word reads idle
  task automatic wait_idle();
    logic [31:0] st;
    st = 32'h1;
    while (st[0]) begin
      host_access(1'b0, `ABR_REG_STATUS, 32'h0, st);
    end
    check_val("rdata_o status", 32'h0, st);
  endtask

  // galois LFSR shifting right with taps on a dropped one
  task automatic model_sample(input logic [15:0] seed, input int dst);
    logic [15:0] st;
    int          k;
    int          steps;
    st    = seed;
    k     = 0;
    steps = 0;
    while (k < N) begin
      st = st[0] ? ((st >> 1) ^ 16'hB400) : (st >> 1);
      steps++;
      if (st[11:0] < Q) begin
        model_mem[(dst + k) & ADDR_MASK] = 32'(st[11:0]);
        k++;
      end
      if (steps > 65536) begin
        stop_on_error("sampler model found too few candidates below Q");
      end
    end
  endtask

  task automatic model_pwo(input int op, input int a, input int b, input int d);
    int av;
    int bv;
    for (int i = 0; i < N; i++) begin
      av = model_mem[(a + i) & ADDR_MASK];
      bv = model_mem[(b + i) & ADDR_MASK];
      model_mem[(d + i) & ADDR_MASK] = (op == OP_PWM) ? (av * bv) % Q : (av + bv) % Q;
    end
  endtask

  task automatic reg_tests();
    logic [31:0] v;
    int          addr;
    for (int i = 0; i < N_REG; i++) begin
      v = $urandom;
      case ($urandom % 3)
        0: begin
          reg_write(`ABR_REG_SEED, v);
          seed_m = v[15:0];
          reg_check(`ABR_REG_SEED, 32'(seed_m), "rdata_o seed");
        end
        1: begin
          reg_write(`ABR_REG_BASES, v);
          bases_m = v[23:0];
          reg_check(`ABR_REG_BASES, 32'(bases_m), "rdata_o bases");
        end
        default: begin
          // unmapped space below and above the window
          addr = ($urandom % 2) ? 4 + $urandom % 252 : 512 + $urandom % 512;
          reg_write(addr, v);
          reg_check(addr, 32'h0, $sformatf("rdata_o unused 0x%03h", addr));
        end
      endcase
    end
  endtask

  task automatic window_tests();
    int addr;
    for (int i = 0; i < DEPTH; i++) begin
      win_write(i, $urandom % Q);
    end
    for (int i = 0; i < N_WIN; i++) begin
      addr = $urandom % DEPTH;
      if ($urandom % 2) begin
        win_write(addr, $urandom);
      end else begin
        win_check(addr);
      end
    end
  endtask

  task automatic sample_run();
    logic [15:0] seed_v;
    logic [7:0]  d;
    seed_v = 16'(($urandom % 65535) + 1);
    d      = 8'($urandom);
    reg_write(`ABR_REG_SEED, 32'(seed_v));
    reg_write(`ABR_REG_BASES, {8'h0, d, 16'($urandom)});
    reg_write(`ABR_REG_CMD, OP_SAMPLE);
    model_sample(seed_v, d);
    wait_idle();
    // one word on either side must survive
    compare_region((d - 1) & ADDR_MASK, N + 2);
  endtask

  task automatic pwo_run(input int op, input bit poke);
    int a;
    int b;
    int d;
    int f;
    int addr;
    a = $urandom % DEPTH;
    b = (a + 64) & ADDR_MASK;
    d = (a + 128) & ADDR_MASK;
    f = (a + 192) & ADDR_MASK;
    for (int i = 0; i < N; i++) begin
      win_write((a + i) & ADDR_MASK, $urandom % Q);
      win_write((b + i) & ADDR_MASK, $urandom % Q);
    end
    reg_write(`ABR_REG_BASES, {8'h0, 8'(d), 8'(b), 8'(a)});
    reg_write(`ABR_REG_CMD, op);
    model_pwo(op, a, b, d);
    if (poke) begin
      // second command lands while the engine is busy
      reg_write(`ABR_REG_CMD, OP_SAMPLE);
      reg_check(`ABR_REG_STATUS, 32'h1, "rdata_o status busy");
      for (int i = 0; i < 8; i++) begin
        addr = (f + 4 * i) & ADDR_MASK;
        win_write(addr, $urandom % Q);
        win_check(addr);
      end
    end
    wait_idle();
    compare_region(a, N);
    compare_region(b, N);
    compare_region(d, N);
    if (poke) begin
      compare_region(f, N);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_error($sformatf("timeout after %0d cycles, the run did not finish",
                            WATCHDOG_CYCLES));
  end

  initial begin
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    seed_m  = '0;
    bases_m = '0;
    void'($urandom(86));
    @(posedge rst_b);
    @(posedge clk);
    #DRIVE_DLY;
    reg_check(`ABR_REG_STATUS, 32'h0, "rdata_o status after reset");
    reg_tests();
    window_tests();
    for (int i = 0; i < N_SAMP; i++) begin
      sample_run();
    end
    pwo_run(OP_PWA, 1'b0);
    pwo_run(OP_PWM, 1'b0);
    pwo_run(OP_PWA, 1'b0);
    pwo_run(OP_PWM, 1'b1);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
logic/abr_pkg.sv
logic/abr_mem_if.sv
logic/abr_reg_front.sv
logic/abr_sampler.sv
logic/abr_pwo_engine.sv
logic/abr_mem_arb.sv
logic/abr_sram.sv
logic/abr_top.sv
test/tb_clkgen.sv
test/abr_tb.sv

/* Bender.yml */
package:
  name: abr

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/abr_pkg.sv
      - logic/abr_mem_if.sv
      - logic/abr_reg_front.sv
      - logic/abr_sampler.sv
      - logic/abr_pwo_engine.sv
      - logic/abr_mem_arb.sv
      - logic/abr_sram.sv
      - logic/abr_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clkgen.sv
      - test/abr_tb.sv
